// ==== logic/shell_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, defaults, control-word field map and status-bus structs
// for the memory-channel status shell
////////////////////////////////////////////////////////////////////////////

package shell_pkg;

   // Status bus widths
   localparam int stat_addr_w = 8;
   localparam int stat_data_w = 32;
   localparam int stat_int_w  = 8;

   // Defaults for the top-level parameters
   localparam int num_stat_chan_default = 3;
   localparam int cfg_stages_default    = 8;

   // Raw reset input pipeline depth
   localparam int rst_pipe_stages = 4;

   // Host control word field positions
   // Note that D sits below C in the word
   localparam int ctl_scrb_a_bit  = 0;
   localparam int ctl_scrb_b_bit  = 1;
   localparam int ctl_scrb_d_bit  = 2;
   localparam int ctl_scrb_c_bit  = 3;
   localparam int ctl_dbg_en_bit  = 31;
   localparam int ctl_dbg_sel_lsb = 28;
   localparam int ctl_dbg_sel_msb = 30;

   // Host to memory controller request, 42 bits
   typedef struct packed {
      logic                   wr;
      logic                   rd;
      logic [stat_addr_w-1:0] addr;
      logic [stat_data_w-1:0] wdata;
   } stat_req_t;

   // Memory controller to host acknowledge, 41 bits
   typedef struct packed {
      logic                   ack;
      logic [stat_int_w-1:0]  intr;
      logic [stat_data_w-1:0] rdata;
   } stat_ack_t;

endpackage

// ==== logic/lib_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// Retiming delay line for long routes; payload type and depth are set by
// the instantiating module, output lags input by exactly stages cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lib_pipe
#(
   parameter type payload_t = logic,
   parameter int  stages    = 4
)
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  payload_t in_bus,
   output payload_t out_bus
);

   // One register per retiming stage, index 0 nearest the input
   payload_t pipe_q [stages];

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < stages; i++)
         begin
            pipe_q[i] <= '0;
         end
      end
      else
      begin
         pipe_q[0] <= in_bus;
         // Shift the rest down by one each cycle
         for (int i = 1; i < stages; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   assign out_bus = pipe_q[stages-1];

endmodule

// ==== logic/rst_sync.sv ====
////////////////////////////////////////////////////////////////////////////
// Turns the raw board reset into the design reset: asserts at once,
// releases rst_pipe_stages plus 2 clock edges after the raw reset rises
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rst_sync
(
   input  logic clk,
   input  logic rst_main_n,
   output logic sync_rst_n
);

   import shell_pkg::*;

   // Input pipeline, shifts in ones once the raw reset is gone
   logic [rst_pipe_stages-1:0] pipe_q;
   logic                       pipe_rst_n;
   logic                       pre_sync_rst_n;

   always_ff @(posedge clk or negedge rst_main_n)
   begin
      if (!rst_main_n)
      begin
         pipe_q <= '0;
      end
      else
      begin
         pipe_q <= {pipe_q[rst_pipe_stages-2:0], 1'b1};
      end
   end

   assign pipe_rst_n = pipe_q[rst_pipe_stages-1];

   // Two-flop stage, cleared by the pipeline output
   always_ff @(posedge clk or negedge pipe_rst_n)
   begin
      if (!pipe_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

endmodule

// ==== logic/ctl_capture.sv ====
////////////////////////////////////////////////////////////////////////////
// Registers the host control word and the memory-ready level, then decodes
// the scrub enables and debug fields from the registered word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctl_capture
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic [31:0] ctl0,
   input  logic        ddr_is_ready,
   output logic        scrb_en_a,
   output logic        scrb_en_b,
   output logic        scrb_en_c,
   output logic        scrb_en_d,
   output logic        dbg_scrb_en,
   output logic [2:0]  dbg_scrb_mem_sel,
   output logic        ddr_is_ready_q
);

   import shell_pkg::*;

   logic [31:0] ctl0_q;

   ////////////////////////////////////////////////////////////////////////////
   // Capture
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q <= '0;
      end
      else
      begin
         ctl0_q <= ctl0;
      end
   end

   // Ready level from the memory controllers, one flop of retiming
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_is_ready_q <= 1'b0;
      end
      else
      begin
         ddr_is_ready_q <= ddr_is_ready;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////////////////////

   // Bit 2 drives memory D and bit 3 memory C, as on the card
   assign scrb_en_a = ctl0_q[ctl_scrb_a_bit];
   assign scrb_en_b = ctl0_q[ctl_scrb_b_bit];
   assign scrb_en_d = ctl0_q[ctl_scrb_d_bit];
   assign scrb_en_c = ctl0_q[ctl_scrb_c_bit];

   // Debug enable and memory select
   assign dbg_scrb_en      = ctl0_q[ctl_dbg_en_bit];
   assign dbg_scrb_mem_sel = ctl0_q[ctl_dbg_sel_msb:ctl_dbg_sel_lsb];

endmodule

// ==== logic/ddr_stat_shell.sv ====
////////////////////////////////////////////////////////////////////////////
// Configuration and status shell around the memory channels: design reset,
// control capture, and retimed status-bus paths to each memory controller
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ddr_stat_shell
#(
   parameter int num_stat_chan = shell_pkg::num_stat_chan_default,
   parameter int cfg_stages    = shell_pkg::cfg_stages_default
)
(
   input  logic                               clk,
   input  logic                               rst_main_n,

   // Host control word and memory ready level
   input  logic [31:0]                        ctl0,
   input  logic                               ddr_is_ready,
   output logic                               scrb_en_a,
   output logic                               scrb_en_b,
   output logic                               scrb_en_c,
   output logic                               scrb_en_d,
   output logic                               dbg_scrb_en,
   output logic [2:0]                         dbg_scrb_mem_sel,
   output logic                               ddr_is_ready_q,

   // Host side status bus, per channel
   input  logic                               host_stat_wr    [num_stat_chan],
   input  logic                               host_stat_rd    [num_stat_chan],
   input  logic [shell_pkg::stat_addr_w-1:0]  host_stat_addr  [num_stat_chan],
   input  logic [shell_pkg::stat_data_w-1:0]  host_stat_wdata [num_stat_chan],
   output logic                               host_stat_ack   [num_stat_chan],
   output logic [shell_pkg::stat_int_w-1:0]   host_stat_int   [num_stat_chan],
   output logic [shell_pkg::stat_data_w-1:0]  host_stat_rdata [num_stat_chan],

   // Memory controller side status bus, per channel
   output logic                               ddr_stat_wr     [num_stat_chan],
   output logic                               ddr_stat_rd     [num_stat_chan],
   output logic [shell_pkg::stat_addr_w-1:0]  ddr_stat_addr   [num_stat_chan],
   output logic [shell_pkg::stat_data_w-1:0]  ddr_stat_wdata  [num_stat_chan],
   input  logic                               ddr_stat_ack    [num_stat_chan],
   input  logic [shell_pkg::stat_int_w-1:0]   ddr_stat_int    [num_stat_chan],
   input  logic [shell_pkg::stat_data_w-1:0]  ddr_stat_rdata  [num_stat_chan]
);

   import shell_pkg::*;

   logic sync_rst_n;

   ////////////////////////////////////////////////////////////////////////////
   // Design reset
   ////////////////////////////////////////////////////////////////////////////

   rst_sync u_rst_sync
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .sync_rst_n (sync_rst_n)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Control word and ready capture
   ////////////////////////////////////////////////////////////////////////////

   ctl_capture u_ctl_capture
   (
      .clk              (clk),
      .sync_rst_n       (sync_rst_n),
      .ctl0             (ctl0),
      .ddr_is_ready     (ddr_is_ready),
      .scrb_en_a        (scrb_en_a),
      .scrb_en_b        (scrb_en_b),
      .scrb_en_c        (scrb_en_c),
      .scrb_en_d        (scrb_en_d),
      .dbg_scrb_en      (dbg_scrb_en),
      .dbg_scrb_mem_sel (dbg_scrb_mem_sel),
      .ddr_is_ready_q   (ddr_is_ready_q)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Status bus retiming, one request and one acknowledge pipe per channel
   ////////////////////////////////////////////////////////////////////////////

   for (genvar ch = 0; ch < num_stat_chan; ch++)
   begin : g_chan
      stat_req_t req_in;
      stat_req_t req_out;
      stat_ack_t ack_in;
      stat_ack_t ack_out;

      // Host to memory controller
      assign req_in.wr    = host_stat_wr[ch];
      assign req_in.rd    = host_stat_rd[ch];
      assign req_in.addr  = host_stat_addr[ch];
      assign req_in.wdata = host_stat_wdata[ch];

      lib_pipe
      #(
         .payload_t (stat_req_t),
         .stages    (cfg_stages)
      )
      u_req_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (req_in),
         .out_bus    (req_out)
      );

      assign ddr_stat_wr[ch]    = req_out.wr;
      assign ddr_stat_rd[ch]    = req_out.rd;
      assign ddr_stat_addr[ch]  = req_out.addr;
      assign ddr_stat_wdata[ch] = req_out.wdata;

      // Memory controller back to host
      assign ack_in.ack   = ddr_stat_ack[ch];
      assign ack_in.intr  = ddr_stat_int[ch];
      assign ack_in.rdata = ddr_stat_rdata[ch];

      lib_pipe
      #(
         .payload_t (stat_ack_t),
         .stages    (cfg_stages)
      )
      u_ack_pipe
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .in_bus     (ack_in),
         .out_bus    (ack_out)
      );

      assign host_stat_ack[ch]   = ack_out.ack;
      assign host_stat_int[ch]   = ack_out.intr;
      assign host_stat_rdata[ch] = ack_out.rdata;
   end

endmodule

// ==== bench/ddr_stat_shell_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the status shell, bound into the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ddr_stat_shell_assert
#(
   parameter int num_stat_chan = shell_pkg::num_stat_chan_default,
   parameter int cfg_stages    = shell_pkg::cfg_stages_default
)
(
   input logic        clk,
   input logic        sync_rst_n,
   input logic [31:0] ctl0,
   input logic        scrb_en_d,
   input logic        host_stat_wr [num_stat_chan],
   input logic        ddr_stat_wr  [num_stat_chan],
   input logic        ddr_stat_rd  [num_stat_chan]
);

   // Memory D scrub enable follows control bit 2 after one cycle
   scrb_d_follows_ctl: assert property (@(posedge clk) disable iff (!sync_rst_n)
      scrb_en_d == $past(ctl0[2]))
   else $error("scrb_en_d does not follow ctl0 bit 2 of the previous cycle");

   for (genvar ch = 0; ch < num_stat_chan; ch++)
   begin : g_chan
      no_strobe_in_reset: assert property (@(posedge clk)
         !sync_rst_n |-> (!ddr_stat_wr[ch] && !ddr_stat_rd[ch]))
      else $error("memory-side strobe on channel %0d while in reset", ch);

      // Write strobe reaches the memory side after the full pipe depth
      wr_strobe_delay: assert property (@(posedge clk) disable iff (!sync_rst_n)
         ddr_stat_wr[ch] == $past(host_stat_wr[ch], cfg_stages))
      else $error("ddr_stat_wr on channel %0d does not match the delayed host strobe", ch);
   end

endmodule

bind ddr_stat_shell ddr_stat_shell_assert
#(
   .num_stat_chan (num_stat_chan),
   .cfg_stages    (cfg_stages)
)
u_assert
(
   .clk          (clk),
   .sync_rst_n   (sync_rst_n),
   .ctl0         (ctl0),
   .scrb_en_d    (scrb_en_d),
   .host_stat_wr (host_stat_wr),
   .ddr_stat_wr  (ddr_stat_wr),
   .ddr_stat_rd  (ddr_stat_rd)
);

// ==== bench/tb_ddr_stat_shell.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the status shell: drives host requests, memory acknowledges,
// control words and resets, and checks every output against a reference
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ddr_stat_shell;

   import shell_pkg::*;

   localparam int num_ch     = num_stat_chan_default;
   localparam int stages     = cfg_stages_default;
   localparam int seed       = 20;
   localparam int hist_depth = 64;

   // Control word held during reset. Only the debug enable is set so that
   // the end of reset shows up on dbg_scrb_en
   localparam logic [31:0] ctl_marker = 32'h8000_0000;

   // Test lengths in cycles
   localparam int drain      = stages + 2;
   localparam int len_reset  = 16;
   localparam int len_req    = 200 + drain;
   localparam int len_ack    = 200 + drain;
   localparam int len_ctl    = 100 + drain;
   localparam int len_rdy    = 50 + drain;
   localparam int len_mid    = 50 + 1 + 4 + 16 + 100 + drain;
   localparam int max_cycles = 16 + len_reset + len_req + len_ack + len_ctl + len_rdy
                               + len_mid + 2 * stages + 50;

   // Expected outputs for one cycle
   typedef struct packed {
      logic                   scrb_a;
      logic                   scrb_b;
      logic                   scrb_c;
      logic                   scrb_d;
      logic                   dbg_en;
      logic [2:0]             dbg_sel;
      logic                   rdy;
      stat_req_t [num_ch-1:0] req;
      stat_ack_t [num_ch-1:0] ack;
   } expect_t;

   logic                   clk = 1'b0;
   logic                   rst_main_n;
   logic [31:0]            ctl0;
   logic                   ddr_is_ready;
   logic                   scrb_en_a;
   logic                   scrb_en_b;
   logic                   scrb_en_c;
   logic                   scrb_en_d;
   logic                   dbg_scrb_en;
   logic [2:0]             dbg_scrb_mem_sel;
   logic                   ddr_is_ready_q;
   logic                   host_stat_wr    [num_ch];
   logic                   host_stat_rd    [num_ch];
   logic [stat_addr_w-1:0] host_stat_addr  [num_ch];
   logic [stat_data_w-1:0] host_stat_wdata [num_ch];
   logic                   host_stat_ack   [num_ch];
   logic [stat_int_w-1:0]  host_stat_int   [num_ch];
   logic [stat_data_w-1:0] host_stat_rdata [num_ch];
   logic                   ddr_stat_wr     [num_ch];
   logic                   ddr_stat_rd     [num_ch];
   logic [stat_addr_w-1:0] ddr_stat_addr   [num_ch];
   logic [stat_data_w-1:0] ddr_stat_wdata  [num_ch];
   logic                   ddr_stat_ack    [num_ch];
   logic [stat_int_w-1:0]  ddr_stat_int    [num_ch];
   logic [stat_data_w-1:0] ddr_stat_rdata  [num_ch];

   // Input histories, indexed by the clock edge that sampled them
   logic [31:0] ctl_hist [hist_depth];
   logic        rdy_hist [hist_depth];
   stat_req_t   req_hist [hist_depth][num_ch];
   stat_ack_t   ack_hist [hist_depth][num_ch];

   int   edge_cnt      = 0;
   int   err_cnt       = 0;
   int   check_cnt     = 0;
   int   test_cnt      = 0;
   int   test_err_base = 0;
   logic checking      = 1'b0;

   ddr_stat_shell
   #(
      .num_stat_chan (num_ch),
      .cfg_stages    (stages)
   )
   dut
   (
      .*
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and checks
   ////////////////////////////////////////////////////////////////////////////

   function automatic expect_t model_outputs(int k);
      expect_t     e;
      logic [31:0] w;
      int          src;
      w         = ctl_hist[k % hist_depth];
      e.scrb_a  = w[0];
      e.scrb_b  = w[1];
      e.scrb_d  = w[2];
      e.scrb_c  = w[3];
      e.dbg_en  = w[31];
      e.dbg_sel = w[30:28];
      e.rdy     = rdy_hist[k % hist_depth];
      // Both status paths lag their inputs by the same fixed depth
      src = k - stages + 1;
      for (int ch = 0; ch < num_ch; ch++)
      begin
         e.req[ch] = (src < 0) ? '0 : req_hist[src % hist_depth][ch];
         e.ack[ch] = (src < 0) ? '0 : ack_hist[src % hist_depth][ch];
      end
      return e;
   endfunction

   task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("MISMATCH %s got 0x%0h expected 0x%0h at edge %0d", name, got, exp, edge_cnt);
      end
   endtask

   task automatic compare_outputs(expect_t e);
      string sfx;
      check_value("scrb_en_a", 64'(scrb_en_a), 64'(e.scrb_a));
      check_value("scrb_en_b", 64'(scrb_en_b), 64'(e.scrb_b));
      check_value("scrb_en_c", 64'(scrb_en_c), 64'(e.scrb_c));
      check_value("scrb_en_d", 64'(scrb_en_d), 64'(e.scrb_d));
      check_value("dbg_scrb_en", 64'(dbg_scrb_en), 64'(e.dbg_en));
      check_value("dbg_scrb_mem_sel", 64'(dbg_scrb_mem_sel), 64'(e.dbg_sel));
      check_value("ddr_is_ready_q", 64'(ddr_is_ready_q), 64'(e.rdy));
      for (int ch = 0; ch < num_ch; ch++)
      begin
         sfx = $sformatf("[%0d]", ch);
         check_value({"ddr_stat_wr", sfx}, 64'(ddr_stat_wr[ch]), 64'(e.req[ch].wr));
         check_value({"ddr_stat_rd", sfx}, 64'(ddr_stat_rd[ch]), 64'(e.req[ch].rd));
         check_value({"ddr_stat_addr", sfx}, 64'(ddr_stat_addr[ch]), 64'(e.req[ch].addr));
         check_value({"ddr_stat_wdata", sfx}, 64'(ddr_stat_wdata[ch]), 64'(e.req[ch].wdata));
         check_value({"host_stat_ack", sfx}, 64'(host_stat_ack[ch]), 64'(e.ack[ch].ack));
         check_value({"host_stat_int", sfx}, 64'(host_stat_int[ch]), 64'(e.ack[ch].intr));
         check_value({"host_stat_rdata", sfx}, 64'(host_stat_rdata[ch]), 64'(e.ack[ch].rdata));
      end
   endtask

   // Records the inputs seen at each edge and bounds the run
   always @(posedge clk)
   begin
      edge_cnt = edge_cnt + 1;
      if (!rst_main_n)
      begin
         // Reset empties every pipe stage
         for (int i = 0; i < hist_depth; i++)
         begin
            for (int ch = 0; ch < num_ch; ch++)
            begin
               req_hist[i][ch] = '0;
               ack_hist[i][ch] = '0;
            end
         end
      end
      ctl_hist[edge_cnt % hist_depth] = ctl0;
      rdy_hist[edge_cnt % hist_depth] = ddr_is_ready;
      for (int ch = 0; ch < num_ch; ch++)
      begin
         req_hist[edge_cnt % hist_depth][ch] = {host_stat_wr[ch], host_stat_rd[ch],
                                                host_stat_addr[ch], host_stat_wdata[ch]};
         ack_hist[edge_cnt % hist_depth][ch] = {ddr_stat_ack[ch], ddr_stat_int[ch],
                                                ddr_stat_rdata[ch]};
      end
      if (edge_cnt > max_cycles)
      begin
         $display("Run stopped: tests did not finish within %0d cycles", max_cycles);
         $display("Verification failed");
         $finish;
      end
   end

   // Compare at the falling edge where outputs have settled
   always @(negedge clk)
   begin
      if (!rst_main_n)
      begin
         checking = 1'b0;
         compare_outputs('0);
      end
      else if (!checking && dbg_scrb_en === 1'b1)
      begin
         checking = 1'b1;
      end
      else if (!checking)
      begin
         // Design reset still held after the raw reset has gone
         compare_outputs('0);
      end
      if (checking)
      begin
         compare_outputs(model_outputs(edge_cnt));
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_random(logic reqs, logic acks);
      logic [31:0] rnd;
      for (int ch = 0; ch < num_ch; ch++)
      begin
         rnd = $urandom();
         // Write strobes are busy most cycles so back-to-back requests occur
         host_stat_wr[ch]    = reqs & (rnd[0] | rnd[1]);
         host_stat_rd[ch]    = reqs & rnd[2] & rnd[3];
         host_stat_addr[ch]  = reqs ? rnd[15:8] : '0;
         host_stat_wdata[ch] = reqs ? $urandom() : '0;
         ddr_stat_ack[ch]    = acks & (rnd[4] | rnd[5]);
         ddr_stat_int[ch]    = acks ? rnd[23:16] : '0;
         ddr_stat_rdata[ch]  = acks ? $urandom() : '0;
      end
   endtask

   task automatic run_traffic(int n, logic reqs, logic acks, logic ctls);
      for (int i = 0; i < n; i++)
      begin
         next_cycle();
         drive_random(reqs, acks);
         if (ctls)
         begin
            ctl0 = $urandom();
         end
      end
   endtask

   task automatic idle_cycles(int n);
      for (int i = 0; i < n; i++)
      begin
         next_cycle();
         drive_random(1'b0, 1'b0);
      end
   endtask

   task automatic wait_release();
      do
      begin
         next_cycle();
      end
      while (!checking);
   endtask

   task automatic finish_test(string name);
      int errs;
      errs = err_cnt - test_err_base;
      test_cnt++;
      $display("test %-14s %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
      test_err_base = err_cnt;
   endtask

   initial
   begin
      logic [31:0] rnd;
      void'($urandom(seed));
      rst_main_n   = 1'b0;
      ctl0         = ctl_marker;
      ddr_is_ready = 1'b0;
      drive_random(1'b0, 1'b0);

      repeat (16) next_cycle();
      rst_main_n = 1'b1;
      wait_release();
      finish_test("reset_values");

      run_traffic(len_req - drain, 1'b1, 1'b0, 1'b0);
      idle_cycles(drain);
      finish_test("request_path");

      run_traffic(len_ack - drain, 1'b0, 1'b1, 1'b0);
      idle_cycles(drain);
      finish_test("ack_path");

      run_traffic(len_ctl - drain, 1'b0, 1'b0, 1'b1);
      idle_cycles(drain);
      finish_test("ctl_decode");

      for (int i = 0; i < len_rdy - drain; i++)
      begin
         next_cycle();
         rnd = $urandom();
         if (rnd[1:0] != 2'b00)
         begin
            ddr_is_ready = !ddr_is_ready;
         end
      end
      idle_cycles(drain);
      finish_test("ready_capture");

      // Reset pulse in the middle of full traffic
      // Ready stays high so the captured level has to be held clear
      run_traffic(50, 1'b1, 1'b1, 1'b1);
      next_cycle();
      rst_main_n   = 1'b0;
      ctl0         = ctl_marker;
      ddr_is_ready = 1'b1;
      drive_random(1'b0, 1'b0);
      repeat (4) next_cycle();
      rst_main_n = 1'b1;
      wait_release();
      run_traffic(100, 1'b1, 1'b1, 1'b0);
      idle_cycles(drain);
      finish_test("mid_reset");

      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
logic/shell_pkg.sv
logic/lib_pipe.sv
logic/rst_sync.sv
logic/ctl_capture.sv
logic/ddr_stat_shell.sv
bench/ddr_stat_shell_assert.sv
bench/tb_ddr_stat_shell.sv

// ==== Makefile ====
# Verilator build and run of the status shell testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_ddr_stat_shell
	-./obj_dir/Vtb_ddr_stat_shell > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@if ! grep -q "Verification passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
